//--- design/mem_pipe_pkg.sv
// Memory pipeline package: data path widths, operation codes and shared structs
`default_nettype none

package mem_pipe_pkg;

  localparam int dword_w    = 64;
  localparam int vaddr_w    = 39;
  localparam int paddr_w    = 28;
  localparam int page_off_w = 12;
  localparam int vtag_w     = vaddr_w - page_off_w;
  localparam int ptag_w     = paddr_w - page_off_w;
  localparam int reg_addr_w = 5;
  localparam int tlb_els    = 8;
  localparam int tlb_idx_w  = $clog2(tlb_els);
  localparam int ram_words  = 256;
  localparam int ram_idx_w  = $clog2(ram_words);

  typedef logic [dword_w-1:0]    dword_t;
  typedef logic [vaddr_w-1:0]    vaddr_t;
  typedef logic [paddr_w-1:0]    paddr_t;
  typedef logic [vtag_w-1:0]     vtag_t;
  typedef logic [ptag_w-1:0]     ptag_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;
  typedef logic [tlb_idx_w-1:0]  tlb_idx_t;
  typedef logic [ram_idx_w-1:0]  ram_idx_t;

  // Integer loads and stores only
  typedef enum logic [3:0]
  {
    e_op_lb,
    e_op_lbu,
    e_op_lh,
    e_op_lhu,
    e_op_lw,
    e_op_lwu,
    e_op_ld,
    e_op_sb,
    e_op_sh,
    e_op_sw,
    e_op_sd
  } mem_op_e;

  typedef enum logic [1:0]
  {
    e_size_byte,
    e_size_half,
    e_size_word,
    e_size_dword
  } mem_size_e;

  typedef struct packed
  {
    mem_op_e   op;
    reg_addr_t rd_addr;
    dword_t    rs1;
    dword_t    rs2;
    dword_t    imm;
  } mem_req_s;

  // Leaf PTE fields kept per entry
  typedef struct packed
  {
    vtag_t vtag;
    ptag_t ptag;
    logic  r;
    logic  w;
    logic  u;
  } tlb_fill_s;

  typedef struct packed
  {
    logic tlb_load_miss;
    logic tlb_store_miss;
    logic load_misaligned;
    logic store_misaligned;
    logic load_page_fault;
    logic store_page_fault;
  } mem_exc_s;

  typedef struct packed
  {
    dword_t    eaddr;
    mem_size_e size;
    logic      is_load;
    logic      is_store;
    logic      is_signed;
    logic      misaligned;
  } agu_s;

endpackage

`default_nettype wire

//--- design/mem_agu.sv
// Address generation unit: effective address, access size decode and alignment check
`timescale 1ns/10ps
`default_nettype none

module mem_agu
  (input  mem_pipe_pkg::mem_req_s req_i
   , output mem_pipe_pkg::agu_s   agu_o
   );

  always_comb
    begin
      agu_o       = '0;
      agu_o.eaddr = req_i.rs1 + req_i.imm;

      unique case (req_i.op)
        mem_pipe_pkg::e_op_lb, mem_pipe_pkg::e_op_lbu, mem_pipe_pkg::e_op_sb:
          agu_o.size = mem_pipe_pkg::e_size_byte;
        mem_pipe_pkg::e_op_lh, mem_pipe_pkg::e_op_lhu, mem_pipe_pkg::e_op_sh:
          agu_o.size = mem_pipe_pkg::e_size_half;
        mem_pipe_pkg::e_op_lw, mem_pipe_pkg::e_op_lwu, mem_pipe_pkg::e_op_sw:
          agu_o.size = mem_pipe_pkg::e_size_word;
        default:
          agu_o.size = mem_pipe_pkg::e_size_dword;
      endcase

      agu_o.is_load   = req_i.op inside {mem_pipe_pkg::e_op_lb, mem_pipe_pkg::e_op_lbu,
                                         mem_pipe_pkg::e_op_lh, mem_pipe_pkg::e_op_lhu,
                                         mem_pipe_pkg::e_op_lw, mem_pipe_pkg::e_op_lwu,
                                         mem_pipe_pkg::e_op_ld};
      agu_o.is_store  = req_i.op inside {mem_pipe_pkg::e_op_sb, mem_pipe_pkg::e_op_sh,
                                         mem_pipe_pkg::e_op_sw, mem_pipe_pkg::e_op_sd};
      // ld needs no extension, so only the narrow signed loads
      agu_o.is_signed = req_i.op inside {mem_pipe_pkg::e_op_lb, mem_pipe_pkg::e_op_lh,
                                         mem_pipe_pkg::e_op_lw};

      // Natural alignment to the access size
      case (agu_o.size)
        mem_pipe_pkg::e_size_half:  agu_o.misaligned = agu_o.eaddr[0];
        mem_pipe_pkg::e_size_word:  agu_o.misaligned = |agu_o.eaddr[1:0];
        mem_pipe_pkg::e_size_dword: agu_o.misaligned = |agu_o.eaddr[2:0];
        default:                    agu_o.misaligned = 1'b0;
      endcase
    end

  // A legal op decodes to a known size and exactly one class
  always_comb
    if (req_i.op <= mem_pipe_pkg::e_op_sd)
      assert final (!$isunknown(agu_o.size) && (agu_o.is_load != agu_o.is_store));

endmodule

`default_nettype wire

//--- design/mem_dtlb.sv
// Data TLB: fully associative, round-robin fill, sfence flush, lookup and permission check
`timescale 1ns/10ps
`default_nettype none

module mem_dtlb
  (input                            clk_i
   , input                          arst_n_i

   , input                          sfence_i
   , input                          fill_v_i
   , input  mem_pipe_pkg::tlb_fill_s fill_i

   , input                          lookup_v_i
   , input                          trans_en_i
   , input                          priv_user_i
   , input  mem_pipe_pkg::vaddr_t   vaddr_i
   , input                          is_load_i
   , input                          is_store_i

   , output mem_pipe_pkg::paddr_t   paddr_o
   , output logic                   miss_o
   , output logic                   page_fault_o
   );

  logic [mem_pipe_pkg::tlb_els-1:0] valid_r;
  mem_pipe_pkg::tlb_fill_s          entry_r [mem_pipe_pkg::tlb_els];
  mem_pipe_pkg::tlb_idx_t           rr_ptr_r;

  logic                             fill_hit;
  mem_pipe_pkg::tlb_idx_t           fill_idx;

  mem_pipe_pkg::vtag_t              lookup_vtag;
  logic [mem_pipe_pkg::tlb_els-1:0] hit_vec;
  logic                             hit;
  mem_pipe_pkg::tlb_fill_s          hit_entry;
  logic                             perm_fault;

  // Refill of a present vtag reuses its slot
  always_comb
    begin
      fill_hit = 1'b0;
      fill_idx = rr_ptr_r;
      for (int i = 0; i < mem_pipe_pkg::tlb_els; i++)
        if (valid_r[i] && (entry_r[i].vtag == fill_i.vtag))
          begin
            fill_hit = 1'b1;
            fill_idx = mem_pipe_pkg::tlb_idx_t'(i);
          end
    end

  // sfence takes priority over a fill in the same cycle
  always_ff @(posedge clk_i or negedge arst_n_i)
    if (!arst_n_i)
      begin
        valid_r  <= '0;
        rr_ptr_r <= '0;
      end
    else if (sfence_i)
      valid_r <= '0;
    else if (fill_v_i)
      begin
        valid_r[fill_idx] <= 1'b1;
        if (!fill_hit)
          rr_ptr_r <= rr_ptr_r + mem_pipe_pkg::tlb_idx_t'(1);
      end

  always_ff @(posedge clk_i)
    if (fill_v_i && !sfence_i)
      entry_r[fill_idx] <= fill_i;

  assign lookup_vtag = vaddr_i[mem_pipe_pkg::vaddr_w-1 -: mem_pipe_pkg::vtag_w];

  always_comb
    begin
      hit_entry = '0;
      for (int i = 0; i < mem_pipe_pkg::tlb_els; i++)
        begin
          hit_vec[i] = valid_r[i] && (entry_r[i].vtag == lookup_vtag);
          if (hit_vec[i])
            hit_entry = entry_r[i];
        end
    end

  assign hit = |hit_vec;

  // User pages only from user mode, supervisor pages only from supervisor mode
  assign perm_fault = (is_load_i && !hit_entry.r)
                    | (is_store_i && !hit_entry.w)
                    | (priv_user_i != hit_entry.u);

  assign miss_o       = lookup_v_i & trans_en_i & ~hit;
  assign page_fault_o = lookup_v_i & trans_en_i & hit & perm_fault;

  assign paddr_o = trans_en_i
                 ? {hit_entry.ptag, vaddr_i[mem_pipe_pkg::page_off_w-1:0]}
                 : vaddr_i[mem_pipe_pkg::paddr_w-1:0];

  // Fill reuse of matching slots keeps every vtag unique
  assert property (@(posedge clk_i) disable iff (!arst_n_i) $onehot0(hit_vec));

endmodule

`default_nettype wire

//--- design/mem_data_ram.sv
// Data memory: doubleword array with byte-lane stores and registered, extended loads
`timescale 1ns/10ps
`default_nettype none

module mem_data_ram
  (input                              clk_i
   , input                            we_i
   , input                            re_i
   , input  mem_pipe_pkg::paddr_t     paddr_i
   , input  mem_pipe_pkg::mem_size_e  size_i
   , input                            signed_i
   , input  mem_pipe_pkg::dword_t     wdata_i
   , output mem_pipe_pkg::dword_t     rdata_o
   );

  mem_pipe_pkg::dword_t    mem_r [mem_pipe_pkg::ram_words];

  mem_pipe_pkg::ram_idx_t  idx;
  logic [2:0]              off;
  logic [7:0]              size_mask;
  logic [7:0]              wmask;
  mem_pipe_pkg::dword_t    wdata_sh;

  mem_pipe_pkg::dword_t    rd_word_r;
  logic [2:0]              rd_off_r;
  mem_pipe_pkg::mem_size_e rd_size_r;
  logic                    rd_signed_r;
  mem_pipe_pkg::dword_t    rd_shift;

  assign idx = paddr_i[10:3];
  assign off = paddr_i[2:0];

  always_comb
    case (size_i)
      mem_pipe_pkg::e_size_byte: size_mask = 8'h01;
      mem_pipe_pkg::e_size_half: size_mask = 8'h03;
      mem_pipe_pkg::e_size_word: size_mask = 8'h0f;
      default:                   size_mask = 8'hff;
    endcase

  // Store data moves from the low bytes up to its lane
  assign wmask    = size_mask << off;
  assign wdata_sh = wdata_i << {off, 3'b000};

  always_ff @(posedge clk_i)
    begin
      for (int i = 0; i < 8; i++)
        if (we_i && wmask[i])
          mem_r[idx][i*8 +: 8] <= wdata_sh[i*8 +: 8];
    end

  always_ff @(posedge clk_i)
    if (re_i)
      begin
        rd_word_r   <= mem_r[idx];
        rd_off_r    <= off;
        rd_size_r   <= size_i;
        rd_signed_r <= signed_i;
      end

  assign rd_shift = rd_word_r >> {rd_off_r, 3'b000};

  always_comb
    case (rd_size_r)
      mem_pipe_pkg::e_size_byte:
        rdata_o = {{56{rd_signed_r & rd_shift[7]}}, rd_shift[7:0]};
      mem_pipe_pkg::e_size_half:
        rdata_o = {{48{rd_signed_r & rd_shift[15]}}, rd_shift[15:0]};
      mem_pipe_pkg::e_size_word:
        rdata_o = {{32{rd_signed_r & rd_shift[31]}}, rd_shift[31:0]};
      default:
        rdata_o = rd_shift;
    endcase

  // Only one request sits in stage 1 at a time
  assert property (@(posedge clk_i) !(we_i && re_i));

endmodule

`default_nettype wire

//--- design/mem_pipe_top.sv
// Memory pipeline top: AGU and TLB in stage 0, exceptions in stage 1, load data in stage 2
`timescale 1ns/10ps
`default_nettype none

module mem_pipe_top
  (input                               clk_i
   , input                             arst_n_i

   , input                             req_v_i
   , input  mem_pipe_pkg::mem_req_s    req_i

   , input                             trans_en_i
   , input                             priv_user_i
   , input                             sfence_i
   , input                             fill_v_i
   , input  mem_pipe_pkg::tlb_fill_s   fill_i

   , output logic                      result_v_o
   , output mem_pipe_pkg::mem_exc_s    exc_o

   , output logic                      early_v_o
   , output mem_pipe_pkg::dword_t      early_data_o
   , output mem_pipe_pkg::reg_addr_t   early_rd_addr_o
   );

  mem_pipe_pkg::agu_s      agu;
  mem_pipe_pkg::paddr_t    paddr;
  logic                    tlb_miss;
  logic                    tlb_page_fault;
  mem_pipe_pkg::mem_exc_s  exc_s0;

  logic                    s1_v_r;
  mem_pipe_pkg::agu_s      s1_agu_r;
  mem_pipe_pkg::paddr_t    s1_paddr_r;
  mem_pipe_pkg::mem_exc_s  s1_exc_r;
  mem_pipe_pkg::reg_addr_t s1_rd_addr_r;
  mem_pipe_pkg::dword_t    s1_wdata_r;
  logic                    s1_ok;

  logic                    s2_v_r;
  mem_pipe_pkg::reg_addr_t s2_rd_addr_r;

  mem_agu agu_u
    (.req_i(req_i)
     ,.agu_o(agu)
     );

  mem_dtlb dtlb_u
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.sfence_i(sfence_i)
     ,.fill_v_i(fill_v_i)
     ,.fill_i(fill_i)
     ,.lookup_v_i(req_v_i)
     ,.trans_en_i(trans_en_i)
     ,.priv_user_i(priv_user_i)
     ,.vaddr_i(agu.eaddr[mem_pipe_pkg::vaddr_w-1:0])
     ,.is_load_i(agu.is_load)
     ,.is_store_i(agu.is_store)
     ,.paddr_o(paddr)
     ,.miss_o(tlb_miss)
     ,.page_fault_o(tlb_page_fault)
     );

  always_comb
    begin
      exc_s0.tlb_load_miss    = tlb_miss & agu.is_load;
      exc_s0.tlb_store_miss   = tlb_miss & agu.is_store;
      exc_s0.load_misaligned  = agu.misaligned & agu.is_load;
      exc_s0.store_misaligned = agu.misaligned & agu.is_store;
      exc_s0.load_page_fault  = tlb_page_fault & agu.is_load;
      exc_s0.store_page_fault = tlb_page_fault & agu.is_store;
    end

  always_ff @(posedge clk_i or negedge arst_n_i)
    if (!arst_n_i)
      begin
        s1_v_r <= 1'b0;
        s2_v_r <= 1'b0;
      end
    else
      begin
        s1_v_r <= req_v_i;
        s2_v_r <= s1_ok & s1_agu_r.is_load;
      end

  always_ff @(posedge clk_i)
    begin
      s1_agu_r     <= agu;
      s1_paddr_r   <= paddr;
      s1_exc_r     <= exc_s0;
      s1_rd_addr_r <= req_i.rd_addr;
      s1_wdata_r   <= req_i.rs2;
      s2_rd_addr_r <= s1_rd_addr_r;
    end

  // Any exception blocks the memory access
  assign s1_ok = s1_v_r & ~(|s1_exc_r);

  mem_data_ram ram_u
    (.clk_i(clk_i)
     ,.we_i(s1_ok & s1_agu_r.is_store)
     ,.re_i(s1_ok & s1_agu_r.is_load)
     ,.paddr_i(s1_paddr_r)
     ,.size_i(s1_agu_r.size)
     ,.signed_i(s1_agu_r.is_signed)
     ,.wdata_i(s1_wdata_r)
     ,.rdata_o(early_data_o)
     );

  assign result_v_o      = s1_v_r;
  assign exc_o           = s1_exc_r;
  assign early_v_o       = s2_v_r;
  assign early_rd_addr_o = s2_rd_addr_r;

endmodule

`default_nettype wire

//--- include/tb_mem_ref.svh
// Reference model for the memory pipeline: shadow TLB, shadow memory and expected results
`ifndef TB_MEM_REF_SVH
`define TB_MEM_REF_SVH

logic [mem_pipe_pkg::tlb_els-1:0] shadow_valid;
mem_pipe_pkg::tlb_fill_s          shadow_tlb [mem_pipe_pkg::tlb_els];
int                               shadow_rr;
mem_pipe_pkg::dword_t             shadow_mem [mem_pipe_pkg::ram_words];

function automatic int op_bytes(input mem_pipe_pkg::mem_op_e op);
  case (op)
    mem_pipe_pkg::e_op_lb, mem_pipe_pkg::e_op_lbu, mem_pipe_pkg::e_op_sb: return 1;
    mem_pipe_pkg::e_op_lh, mem_pipe_pkg::e_op_lhu, mem_pipe_pkg::e_op_sh: return 2;
    mem_pipe_pkg::e_op_lw, mem_pipe_pkg::e_op_lwu, mem_pipe_pkg::e_op_sw: return 4;
    default: return 8;
  endcase
endfunction

// Present vtag keeps its slot, otherwise next round-robin slot
function automatic void record_fill(input mem_pipe_pkg::tlb_fill_s fill);
  int slot;
  slot = -1;
  for (int i = 0; i < mem_pipe_pkg::tlb_els; i++)
    if (shadow_valid[i] && (shadow_tlb[i].vtag == fill.vtag))
      slot = i;
  if (slot < 0)
    begin
      slot      = shadow_rr;
      shadow_rr = (shadow_rr + 1) % mem_pipe_pkg::tlb_els;
    end
  shadow_tlb[slot]   = fill;
  shadow_valid[slot] = 1'b1;
endfunction

function automatic mem_pipe_pkg::mem_exc_s ref_access
  (input mem_pipe_pkg::mem_req_s req, input logic trans_en, input logic priv_user,
   output logic load_ok, output mem_pipe_pkg::dword_t load_data);
  mem_pipe_pkg::mem_exc_s  exc;
  mem_pipe_pkg::tlb_fill_s ent;
  mem_pipe_pkg::dword_t    ea;
  mem_pipe_pkg::dword_t    word;
  mem_pipe_pkg::dword_t    mask;
  mem_pipe_pkg::paddr_t    pa;
  logic                    is_ld;
  logic                    hit;
  logic                    bad;
  int                      nb;
  ea    = req.rs1 + req.imm;
  nb    = op_bytes(req.op);
  is_ld = req.op inside {mem_pipe_pkg::e_op_lb, mem_pipe_pkg::e_op_lbu, mem_pipe_pkg::e_op_lh,
                         mem_pipe_pkg::e_op_lhu, mem_pipe_pkg::e_op_lw, mem_pipe_pkg::e_op_lwu,
                         mem_pipe_pkg::e_op_ld};
  exc   = '0;
  hit   = 1'b0;
  ent   = '0;
  pa    = ea[mem_pipe_pkg::paddr_w-1:0];
  if (trans_en)
    begin
      for (int i = 0; i < mem_pipe_pkg::tlb_els; i++)
        if (shadow_valid[i] && (shadow_tlb[i].vtag
                                == ea[mem_pipe_pkg::vaddr_w-1:mem_pipe_pkg::page_off_w]))
          begin
            hit = 1'b1;
            ent = shadow_tlb[i];
          end
      bad = (is_ld ? !ent.r : !ent.w) || (priv_user != ent.u);
      exc.tlb_load_miss    = !hit && is_ld;
      exc.tlb_store_miss   = !hit && !is_ld;
      exc.load_page_fault  = hit && bad && is_ld;
      exc.store_page_fault = hit && bad && !is_ld;
      pa = {ent.ptag, ea[mem_pipe_pkg::page_off_w-1:0]};
    end
  exc.load_misaligned  = ((ea[2:0] & 3'(nb - 1)) != 3'b000) && is_ld;
  exc.store_misaligned = ((ea[2:0] & 3'(nb - 1)) != 3'b000) && !is_ld;
  load_ok   = is_ld && (exc == '0);
  word      = shadow_mem[pa[10:3]];
  mask      = (nb == 8) ? '1 : ((64'd1 << (8 * nb)) - 64'd1);
  load_data = (word >> (8 * pa[2:0])) & mask;
  if ((req.op inside {mem_pipe_pkg::e_op_lb, mem_pipe_pkg::e_op_lh, mem_pipe_pkg::e_op_lw})
      && load_data[8*nb-1])
    load_data = load_data | ~mask;
  if (!is_ld && (exc == '0))
    begin
      for (int b = 0; b < nb; b++)
        word[8*(pa[2:0]+b) +: 8] = req.rs2[8*b +: 8];
      shadow_mem[pa[10:3]] = word;
    end
  return exc;
endfunction

`endif

//--- verif/tb_mem_pipe.sv
// Testbench for the memory pipeline: directed and random accesses against a reference model
`timescale 1ns/10ps
`default_nettype none

module tb_mem_pipe;

  localparam int n_mixed    = 16;
  localparam int n_rand     = 200;
  localparam int n_fills    = 8;
  // Init, mixed, alias, miss, misaligned, permission, sfence and random phases
  localparam int n_reqs     = mem_pipe_pkg::ram_words + n_mixed * 8 + 16 + 3 + 6 + 7 + 1 + n_rand;
  localparam int max_cycles = (n_reqs + n_fills) * 4 + 100;
  localparam mem_pipe_pkg::vtag_t pages [5] = '{27'h0_0123, 27'h0_4567, 27'h1_89ab,
                                                27'h2_cdef, 27'h3_0f0f};

  typedef struct packed
  {
    logic [31:0]            due;
    mem_pipe_pkg::mem_exc_s exc;
  } res_exp_s;

  typedef struct packed
  {
    logic [31:0]             due;
    mem_pipe_pkg::reg_addr_t rd_addr;
    mem_pipe_pkg::dword_t    data;
  } load_exp_s;

  logic                    clk;
  logic                    arst_n;
  logic                    req_v;
  mem_pipe_pkg::mem_req_s  req;
  logic                    trans_en;
  logic                    priv_user;
  logic                    sfence;
  logic                    fill_v;
  mem_pipe_pkg::tlb_fill_s fill;
  logic                    result_v;
  mem_pipe_pkg::mem_exc_s  exc;
  logic                    early_v;
  mem_pipe_pkg::dword_t    early_data;
  mem_pipe_pkg::reg_addr_t early_rd_addr;

  res_exp_s    res_q [$];
  load_exp_s   early_q [$];
  int unsigned cycle = 0;
  int          errors = 0;
  int          checks = 0;

`include "tb_mem_ref.svh"

  mem_pipe_top uut
    (.clk_i(clk)
     ,.arst_n_i(arst_n)
     ,.req_v_i(req_v)
     ,.req_i(req)
     ,.trans_en_i(trans_en)
     ,.priv_user_i(priv_user)
     ,.sfence_i(sfence)
     ,.fill_v_i(fill_v)
     ,.fill_i(fill)
     ,.result_v_o(result_v)
     ,.exc_o(exc)
     ,.early_v_o(early_v)
     ,.early_data_o(early_data)
     ,.early_rd_addr_o(early_rd_addr)
     );

  function automatic void log_error(input string msg);
    errors++;
    $display("%s", msg);
  endfunction

  function automatic mem_pipe_pkg::dword_t virt_addr(input int page, input logic [11:0] off);
    return mem_pipe_pkg::dword_t'({pages[page], off});
  endfunction

  task automatic send_req(input mem_pipe_pkg::mem_op_e op, input mem_pipe_pkg::dword_t ea,
                          input mem_pipe_pkg::dword_t data);
    mem_pipe_pkg::mem_req_s r;
    mem_pipe_pkg::dword_t   ld_data;
    res_exp_s               re;
    load_exp_s              le;
    logic                   ok;
    logic [11:0]            imm12;
    imm12      = 12'($urandom);
    r.op       = op;
    r.rd_addr  = 5'($urandom);
    r.imm      = {{52{imm12[11]}}, imm12};
    r.rs1      = ea - r.imm;
    r.rs2      = data;
    re.due     = cycle + 1;
    re.exc     = ref_access(r, trans_en, priv_user, ok, ld_data);
    le.due     = cycle + 2;
    le.rd_addr = r.rd_addr;
    le.data    = ld_data;
    res_q.push_back(re);
    if (ok)
      early_q.push_back(le);
    req   = r;
    req_v = 1'b1;
    @(posedge clk);
    #1 req_v = 1'b0;
  endtask

  task automatic drain_pipe;
    while (res_q.size() != 0 || early_q.size() != 0)
      begin
        @(posedge clk);
        #1;
      end
  endtask

  task automatic load_tlb(input int page, input mem_pipe_pkg::ptag_t ptag, input logic [2:0] rwu);
    fill   = {pages[page], ptag, rwu};
    fill_v = 1'b1;
    record_fill(fill);
    @(posedge clk);
    #1 fill_v = 1'b0;
  endtask

  // A and B share a frame, C is read only, D is a user page, E stays unmapped
  task automatic map_pages;
    load_tlb(0, 16'h0a5, 3'b110);
    load_tlb(1, 16'h0a5, 3'b110);
    load_tlb(2, 16'h1c3, 3'b100);
    load_tlb(3, 16'h2e7, 3'b111);
  endtask

  initial
    begin
      clk = 1'b0;
      forever #5 clk = ~clk;
    end

  always @(posedge clk)
    begin
      cycle <= cycle + 1;
      if (cycle >= max_cycles)
        begin
          $display("Timeout: run still going after %0d cycles", cycle);
          $display("TEST FAIL");
          $finish;
        end
    end

  always @(negedge clk)
    begin
      res_exp_s  re;
      load_exp_s le;
      if (res_q.size() != 0 && res_q[0].due == cycle)
        begin
          re = res_q.pop_front();
          checks++;
          if (!result_v)
            log_error($sformatf("result_v_o missing at cycle %0d", cycle));
          else if (exc !== re.exc)
            log_error($sformatf("Mismatch exc_o: got 0x%h, expected 0x%h", exc, re.exc));
        end
      else if (result_v)
        log_error($sformatf("result_v_o high with no request at cycle %0d", cycle));
      if (early_q.size() != 0 && early_q[0].due == cycle)
        begin
          le = early_q.pop_front();
          checks++;
          if (!early_v)
            log_error($sformatf("early_v_o missing for a load at cycle %0d", cycle));
          if (early_v && early_data !== le.data)
            log_error($sformatf("Mismatch early_data_o: got 0x%h, expected 0x%h",
                                early_data, le.data));
          if (early_v && early_rd_addr !== le.rd_addr)
            log_error($sformatf("Mismatch early_rd_addr_o: got 0x%h, expected 0x%h",
                                early_rd_addr, le.rd_addr));
        end
      else if (early_v)
        log_error($sformatf("early_v_o high with no good load at cycle %0d", cycle));
    end

  initial
    begin
      mem_pipe_pkg::dword_t  addr [n_mixed];
      mem_pipe_pkg::mem_op_e op;
      logic [11:0]           off;
      void'($urandom(32'hdea0_4143));
      arst_n       = 1'b0;
      req_v        = 1'b0;
      req          = '0;
      trans_en     = 1'b0;
      priv_user    = 1'b0;
      sfence       = 1'b0;
      fill_v       = 1'b0;
      fill         = '0;
      shadow_valid = '0;
      shadow_rr    = 0;
      repeat (5) @(posedge clk);
      #1 arst_n = 1'b1;

      // Known contents in every word before any load
      for (int i = 0; i < mem_pipe_pkg::ram_words; i++)
        send_req(mem_pipe_pkg::e_op_sd, 64'(i * 8), 64'(i + 1) * 64'h9e37_79b9_7f4a_7c15);
      for (int i = 0; i < n_mixed; i++)
        begin
          op      = mem_pipe_pkg::mem_op_e'($urandom_range(10, 7));
          addr[i] = {$urandom, $urandom} & ~64'(op_bytes(op) - 1);
          send_req(op, addr[i], {$urandom, $urandom});
        end
      for (int i = 0; i < n_mixed; i++)
        for (int k = 0; k < 7; k++)
          send_req(mem_pipe_pkg::mem_op_e'(k),
                   addr[i] & ~64'(op_bytes(mem_pipe_pkg::mem_op_e'(k)) - 1), '0);
      drain_pipe;

      trans_en = 1'b1;
      map_pages;
      for (int i = 0; i < 8; i++)
        begin
          off = 12'($urandom) & 12'hff8;
          send_req(mem_pipe_pkg::mem_op_e'($urandom_range(10, 7)), virt_addr(0, off),
                   {$urandom, $urandom});
          send_req(mem_pipe_pkg::e_op_ld, virt_addr(1, off), '0);
        end
      send_req(mem_pipe_pkg::e_op_ld, virt_addr(4, 12'h348), '0);
      send_req(mem_pipe_pkg::e_op_sd, virt_addr(4, 12'h348), 64'hdead_beef_0bad_f00d);
      send_req(mem_pipe_pkg::e_op_ld, virt_addr(0, 12'h348), '0);
      // lh, lw, ld, sh, sw, sd at odd offsets
      for (int k = 0; k < 6; k++)
        send_req(mem_pipe_pkg::mem_op_e'(k < 3 ? 2 + 2 * k : 5 + k),
                 virt_addr(0, 12'(12'h101 + 16 * k)), 64'(k));
      send_req(mem_pipe_pkg::e_op_sd, virt_addr(2, 12'h010), 64'h4);
      send_req(mem_pipe_pkg::e_op_ld, virt_addr(2, 12'h010), '0);
      send_req(mem_pipe_pkg::e_op_ld, virt_addr(3, 12'h018), '0);
      drain_pipe;
      priv_user = 1'b1;
      send_req(mem_pipe_pkg::e_op_ld, virt_addr(0, 12'h020), '0);
      send_req(mem_pipe_pkg::e_op_sd, virt_addr(0, 12'h020), 64'h5);
      send_req(mem_pipe_pkg::e_op_ld, virt_addr(3, 12'h028), '0);
      send_req(mem_pipe_pkg::e_op_sw, virt_addr(3, 12'h028), 64'h6);
      drain_pipe;
      priv_user = 1'b0;

      sfence = 1'b1;
      shadow_valid = '0;
      @(posedge clk);
      #1 sfence = 1'b0;
      send_req(mem_pipe_pkg::e_op_ld, virt_addr(0, 12'h030), '0);
      map_pages;
      // Back to back, mostly aligned
      for (int i = 0; i < n_rand; i++)
        begin
          op  = mem_pipe_pkg::mem_op_e'($urandom_range(10, 0));
          off = 12'($urandom);
          if ($urandom_range(3, 0) != 0)
            off = off & ~12'(op_bytes(op) - 1);
          send_req(op, virt_addr($urandom_range(4, 0), off), {$urandom, $urandom});
        end
      drain_pipe;

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
        $display("TEST PASS");
      else
        $display("TEST FAIL");
      $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
design/mem_pipe_pkg.sv
design/mem_agu.sv
design/mem_dtlb.sv
design/mem_data_ram.sv
design/mem_pipe_top.sv
verif/tb_mem_pipe.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f sim.f --top-module tb_mem_pipe -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_mem_pipe)"; echo "$$out"; \
		echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
